// ==== hdl/soc_mem_pkg.sv ====
package soc_mem_pkg;

  // ----------------------------
  // Bus widths
  // ----------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;

  // Word indices into each memory
  typedef logic [3:0]  rom_idx_t;
  typedef logic [9:0]  sram_idx_t;

  // Decoded destination of one request
  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_SRAM,
    TGT_NONE
  } target_e;

  // ----------------------------
  // Address map
  // ----------------------------
  localparam addr_t RomBase   = 32'h0000_1000;
  localparam int    RomWords  = 16;

  localparam addr_t SramBase  = 32'h8000_0000;
  // 4 KiB
  localparam int    SramWords = 1024;

  // ----------------------------
  // Response codes
  // ----------------------------
  localparam resp_t RespOkay   = 2'd0;
  localparam resp_t RespSlvErr = 2'd2;
  localparam resp_t RespDecErr = 2'd3;

  // Boot image with one hex word per line
  localparam string RomImage = "hdl/boot_rom.hex";

endpackage

// ==== hdl/axil_front.sv ====
`timescale 1ns/1ps

module axil_front (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  awvalid_i,
  input  soc_mem_pkg::addr_t    awaddr_i,
  output logic                  awready_o,
  input  logic                  wvalid_i,
  input  soc_mem_pkg::data_t    wdata_i,
  input  soc_mem_pkg::strb_t    wstrb_i,
  output logic                  wready_o,
  input  logic                  arvalid_i,
  input  soc_mem_pkg::addr_t    araddr_i,
  output logic                  arready_o,
  input  logic                  busy_i,
  output logic                  rom_req_o,
  output soc_mem_pkg::rom_idx_t rom_idx_o,
  output logic                  sram_req_o,
  output logic                  sram_we_o,
  output soc_mem_pkg::sram_idx_t sram_idx_o,
  output soc_mem_pkg::data_t    sram_wdata_o,
  output soc_mem_pkg::strb_t    sram_strb_o,
  output logic                  issue_o,
  output logic                  issue_write_o,
  output soc_mem_pkg::target_e  issue_target_o
);
  import soc_mem_pkg::*;

  logic    rd_accept;
  logic    wr_accept;
  logic    accept;
  addr_t   acc_addr;
  addr_t   rom_off;
  addr_t   sram_off;
  target_e acc_target;

  // Reads win and writes need AW and W together
  assign rd_accept = arvalid_i && !busy_i;
  assign wr_accept = awvalid_i && wvalid_i && !arvalid_i && !busy_i;
  assign accept    = rd_accept || wr_accept;

  assign arready_o = rd_accept;
  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;

  // ----------------------------
  // Address decode
  // ----------------------------
  assign acc_addr = rd_accept ? araddr_i : awaddr_i;
  assign rom_off  = acc_addr - RomBase;
  assign sram_off = acc_addr - SramBase;

  always_comb begin
    if (rom_off < addr_t'(RomWords * 4)) begin
      acc_target = TGT_ROM;
    end else if (sram_off < addr_t'(SramWords * 4)) begin
      acc_target = TGT_SRAM;
    end else begin
      acc_target = TGT_NONE;
    end
  end

  // ----------------------------
  // Issue registers
  // ----------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_o    <= 1'b0;
      rom_req_o  <= 1'b0;
      sram_req_o <= 1'b0;
      sram_we_o  <= 1'b0;
    end else begin
      issue_o    <= accept;
      // ROM writes never reach the ROM
      rom_req_o  <= rd_accept && (acc_target == TGT_ROM);
      sram_req_o <= accept && (acc_target == TGT_SRAM);
      sram_we_o  <= wr_accept && (acc_target == TGT_SRAM);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rom_idx_o      <= rom_off[2 +: $bits(rom_idx_t)];
      sram_idx_o     <= sram_off[2 +: $bits(sram_idx_t)];
      sram_wdata_o   <= wdata_i;
      sram_strb_o    <= wstrb_i;
      issue_write_o  <= wr_accept;
      issue_target_o <= acc_target;
    end
  end

endmodule

// ==== hdl/boot_rom.sv ====
`timescale 1ns/1ps

module boot_rom (
  input  logic                  clk_i,
  input  logic                  req_i,
  input  soc_mem_pkg::rom_idx_t idx_i,
  output soc_mem_pkg::data_t    rdata_o
);
  import soc_mem_pkg::*;

  data_t mem [RomWords];

  // Boot image
  initial begin
    $readmemh(RomImage, mem);
  end

  // Output holds between requests
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= mem[idx_i];
    end
  end

endmodule

// ==== hdl/sram_bank.sv ====
`timescale 1ns/1ps

module sram_bank (
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  soc_mem_pkg::sram_idx_t idx_i,
  input  soc_mem_pkg::data_t     wdata_i,
  input  soc_mem_pkg::strb_t     strb_i,
  output soc_mem_pkg::data_t     rdata_o
);
  import soc_mem_pkg::*;

  data_t mem [SramWords];

  initial begin
    for (int i = 0; i < SramWords; i++) begin
      mem[i] = '0;
    end
  end

  // ----------------------------
  // Byte write and registered read
  // ----------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (strb_i[b]) begin
          mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read word left alone by writes
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem[idx_i];
    end
  end

endmodule

// ==== hdl/resp_merge.sv ====
`timescale 1ns/1ps

module resp_merge (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 issue_i,
  input  logic                 issue_write_i,
  input  soc_mem_pkg::target_e issue_target_i,
  input  soc_mem_pkg::data_t   rom_rdata_i,
  input  soc_mem_pkg::data_t   sram_rdata_i,
  output logic                 bvalid_o,
  output soc_mem_pkg::resp_t   bresp_o,
  input  logic                 bready_i,
  output logic                 rvalid_o,
  output soc_mem_pkg::data_t   rdata_o,
  output soc_mem_pkg::resp_t   rresp_o,
  input  logic                 rready_i,
  output logic                 busy_o
);
  import soc_mem_pkg::*;

  logic    bvalid_q;
  logic    rvalid_q;
  target_e tgt_q;

  // ----------------------------
  // Response valids
  // ----------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else if (issue_i) begin
      bvalid_q <= issue_write_i;
      rvalid_q <= !issue_write_i;
    end else begin
      if (bvalid_q && bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rvalid_q && rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      tgt_q <= issue_target_i;
    end
  end

  // Memory outputs hold until the next access, so the mux stays stable
  always_comb begin
    case (tgt_q)
      TGT_ROM: begin
        bresp_o = RespSlvErr;
        rresp_o = RespOkay;
        rdata_o = rom_rdata_i;
      end
      TGT_SRAM: begin
        bresp_o = RespOkay;
        rresp_o = RespOkay;
        rdata_o = sram_rdata_i;
      end
      default: begin
        bresp_o = RespDecErr;
        rresp_o = RespDecErr;
        rdata_o = '0;
      end
    endcase
  end

  assign bvalid_o = bvalid_q;
  assign rvalid_o = rvalid_q;

  // Covers the issue cycle too
  assign busy_o = issue_i || bvalid_q || rvalid_q;

endmodule

// ==== hdl/soc_mem_top.sv ====
`timescale 1ns/1ps

module soc_mem_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               awvalid_i,
  input  soc_mem_pkg::addr_t awaddr_i,
  output logic               awready_o,
  input  logic               wvalid_i,
  input  soc_mem_pkg::data_t wdata_i,
  input  soc_mem_pkg::strb_t wstrb_i,
  output logic               wready_o,
  output logic               bvalid_o,
  output soc_mem_pkg::resp_t bresp_o,
  input  logic               bready_i,
  input  logic               arvalid_i,
  input  soc_mem_pkg::addr_t araddr_i,
  output logic               arready_o,
  output logic               rvalid_o,
  output soc_mem_pkg::data_t rdata_o,
  output soc_mem_pkg::resp_t rresp_o,
  input  logic               rready_i
);
  import soc_mem_pkg::*;

  logic      busy;
  logic      rom_req;
  rom_idx_t  rom_idx;
  data_t     rom_rdata;
  logic      sram_req;
  logic      sram_we;
  sram_idx_t sram_idx;
  data_t     sram_wdata;
  strb_t     sram_strb;
  data_t     sram_rdata;
  logic      issue;
  logic      issue_write;
  target_e   issue_target;

  // ----------------------------
  // Request decode
  // ----------------------------
  axil_front i_front (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .awvalid_i      ( awvalid_i    ),
    .awaddr_i       ( awaddr_i     ),
    .awready_o      ( awready_o    ),
    .wvalid_i       ( wvalid_i     ),
    .wdata_i        ( wdata_i      ),
    .wstrb_i        ( wstrb_i      ),
    .wready_o       ( wready_o     ),
    .arvalid_i      ( arvalid_i    ),
    .araddr_i       ( araddr_i     ),
    .arready_o      ( arready_o    ),
    .busy_i         ( busy         ),
    .rom_req_o      ( rom_req      ),
    .rom_idx_o      ( rom_idx      ),
    .sram_req_o     ( sram_req     ),
    .sram_we_o      ( sram_we      ),
    .sram_idx_o     ( sram_idx     ),
    .sram_wdata_o   ( sram_wdata   ),
    .sram_strb_o    ( sram_strb    ),
    .issue_o        ( issue        ),
    .issue_write_o  ( issue_write  ),
    .issue_target_o ( issue_target )
  );

  // ----------------------------
  // Memories
  // ----------------------------
  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .idx_i   ( rom_idx   ),
    .rdata_o ( rom_rdata )
  );

  sram_bank i_sram_bank (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .we_i    ( sram_we    ),
    .idx_i   ( sram_idx   ),
    .wdata_i ( sram_wdata ),
    .strb_i  ( sram_strb  ),
    .rdata_o ( sram_rdata )
  );

  // ----------------------------
  // Responses
  // ----------------------------
  resp_merge i_resp_merge (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .issue_i        ( issue        ),
    .issue_write_i  ( issue_write  ),
    .issue_target_i ( issue_target ),
    .rom_rdata_i    ( rom_rdata    ),
    .sram_rdata_i   ( sram_rdata   ),
    .bvalid_o       ( bvalid_o     ),
    .bresp_o        ( bresp_o      ),
    .bready_i       ( bready_i     ),
    .rvalid_o       ( rvalid_o     ),
    .rdata_o        ( rdata_o      ),
    .rresp_o        ( rresp_o      ),
    .rready_i       ( rready_i     ),
    .busy_o         ( busy         )
  );

endmodule

// ==== tests/tb_soc_mem.sv ====
`timescale 1ns/1ps

module tb_soc_mem;
  import soc_mem_pkg::*;

  localparam int Timeout  = 50;
  localparam int NumTrans = 400;

  logic  clk_i;
  logic  rst_ni;
  logic  awvalid_i;
  addr_t awaddr_i;
  logic  awready_o;
  logic  wvalid_i;
  data_t wdata_i;
  strb_t wstrb_i;
  logic  wready_o;
  logic  bvalid_o;
  resp_t bresp_o;
  logic  bready_i;
  logic  arvalid_i;
  addr_t araddr_i;
  logic  arready_o;
  logic  rvalid_o;
  data_t rdata_o;
  resp_t rresp_o;
  logic  rready_i;

  // Reference model
  data_t rom_model [RomWords];
  data_t sram_model [SramWords];

  int checks   = 0;
  int errors   = 0;
  int timeouts = 0;

  soc_mem_top UUT (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .awvalid_i ( awvalid_i ),
    .awaddr_i  ( awaddr_i  ),
    .awready_o ( awready_o ),
    .wvalid_i  ( wvalid_i  ),
    .wdata_i   ( wdata_i   ),
    .wstrb_i   ( wstrb_i   ),
    .wready_o  ( wready_o  ),
    .bvalid_o  ( bvalid_o  ),
    .bresp_o   ( bresp_o   ),
    .bready_i  ( bready_i  ),
    .arvalid_i ( arvalid_i ),
    .araddr_i  ( araddr_i  ),
    .arready_o ( arready_o ),
    .rvalid_o  ( rvalid_o  ),
    .rdata_o   ( rdata_o   ),
    .rresp_o   ( rresp_o   ),
    .rready_i  ( rready_i  )
  );

  always #4 clk_i = ~clk_i;

  // ----------------------------
  // Helpers
  // ----------------------------
  task automatic check_equal(input string what, input data_t got, input data_t exp);
    checks++;
    assert (got === exp) else begin
      $display("Error at %0t: %s got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic data_t merge_bytes(input data_t old, input data_t data, input strb_t strb);
    data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Unmapped addresses including the window edges
  function automatic addr_t pick_unmapped();
    addr_t a;
    case ($urandom_range(0, 3))
      0: a = RomBase + addr_t'(RomWords * 4);
      1: a = RomBase - 32'd4;
      2: a = SramBase + addr_t'(SramWords * 4);
      default: begin
        a = $urandom();
        while ((a - RomBase) < RomWords * 4 || (a - SramBase) < SramWords * 4) begin
          a = $urandom();
        end
      end
    endcase
    return a;
  endfunction

  task automatic wait_accept(input bit is_write, output bit ok);
    int cyc;
    cyc = 0;
    do begin
      @(negedge clk_i);
      cyc++;
      if (is_write) begin
        check_equal("awready vs wready", data_t'(awready_o), data_t'(wready_o));
      end
    end while (!(is_write ? (awready_o && wready_o) : arready_o) && cyc < Timeout);
    ok = is_write ? (awready_o && wready_o) : arready_o;
    if (!ok) begin
      $display("Timed out waiting for the %s request to be accepted",
               is_write ? "write" : "read");
      timeouts++;
    end else begin
      // Accept edge
      @(posedge clk_i);
      awvalid_i <= 1'b0;
      wvalid_i  <= 1'b0;
      arvalid_i <= 1'b0;
    end
  endtask

  task automatic collect_response(input bit is_write, input data_t exp_data,
                                  input resp_t exp_resp);
    int cyc;
    int stall;
    cyc = 0;
    do begin
      @(negedge clk_i);
      cyc++;
    end while (!(is_write ? bvalid_o : rvalid_o) && cyc < Timeout);
    if (!(is_write ? bvalid_o : rvalid_o)) begin
      $display("Timed out waiting for the %s response", is_write ? "write" : "read");
      timeouts++;
      return;
    end
    check_equal("response latency", data_t'(cyc), 32'd2);
    check_equal("response code", data_t'(is_write ? bresp_o : rresp_o), data_t'(exp_resp));
    if (!is_write) begin
      check_equal("read data", rdata_o, exp_data);
    end
    // Random back-pressure before one cycle with ready high
    stall = $urandom_range(0, 3);
    for (int s = 0; s <= stall; s++) begin
      if (s == stall) begin
        @(posedge clk_i);
        bready_i <= is_write;
        rready_i <= !is_write;
      end
      @(negedge clk_i);
      check_equal("valid held", data_t'(is_write ? bvalid_o : rvalid_o), 32'd1);
      check_equal("response held", data_t'(is_write ? bresp_o : rresp_o), data_t'(exp_resp));
      if (!is_write) begin
        check_equal("read data held", rdata_o, exp_data);
      end
    end
    @(posedge clk_i);
    bready_i <= 1'b0;
    rready_i <= 1'b0;
  endtask

  task automatic run_read(input addr_t addr, input data_t exp_data, input resp_t exp_resp);
    bit ok;
    @(posedge clk_i);
    arvalid_i <= 1'b1;
    araddr_i  <= addr;
    wait_accept(1'b0, ok);
    if (ok) begin
      collect_response(1'b0, exp_data, exp_resp);
    end
  endtask

  task automatic run_write(input addr_t addr, input data_t data, input strb_t strb,
                           input resp_t exp_resp);
    bit ok;
    int lead;
    // 0 both together, 1 AW first, 2 W first
    lead = $urandom_range(0, 2);
    @(posedge clk_i);
    awvalid_i <= (lead != 2);
    awaddr_i  <= addr;
    wvalid_i  <= (lead != 1);
    wdata_i   <= data;
    wstrb_i   <= strb;
    if (lead != 0) begin
      // Half a write is never accepted
      @(negedge clk_i);
      check_equal("awready with one channel", data_t'(awready_o), 32'd0);
      check_equal("wready with one channel", data_t'(wready_o), 32'd0);
      @(posedge clk_i);
      awvalid_i <= 1'b1;
      wvalid_i  <= 1'b1;
    end
    wait_accept(1'b1, ok);
    if (ok) begin
      collect_response(1'b1, '0, exp_resp);
    end
  endtask

  // ----------------------------
  // Stimulus
  // ----------------------------
  initial begin
    addr_t addr;
    data_t data;
    strb_t strb;
    int    kind;
    int    idx;
    bit    is_write;
    void'($urandom(32'h4ba));
    $readmemh(RomImage, rom_model);
    foreach (sram_model[i]) begin
      sram_model[i] = '0;
    end
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    awvalid_i = 1'b0;
    awaddr_i  = '0;
    wvalid_i  = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    bready_i  = 1'b0;
    arvalid_i = 1'b0;
    araddr_i  = '0;
    rready_i  = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_equal("awready after reset", data_t'(awready_o), 32'd0);
    check_equal("wready after reset", data_t'(wready_o), 32'd0);
    check_equal("arready after reset", data_t'(arready_o), 32'd0);
    check_equal("bvalid after reset", data_t'(bvalid_o), 32'd0);
    check_equal("rvalid after reset", data_t'(rvalid_o), 32'd0);

    // Whole boot image first
    for (int i = 0; i < RomWords && timeouts == 0; i++) begin
      run_read(RomBase + addr_t'(i * 4), rom_model[i], RespOkay);
    end

    for (int n = 0; n < NumTrans && timeouts == 0; n++) begin
      kind     = $urandom_range(0, 2);
      is_write = $urandom_range(0, 1);
      data     = $urandom();
      strb     = strb_t'($urandom_range(0, 15));
      case (kind)
        0: begin
          idx  = $urandom_range(0, RomWords - 1);
          addr = RomBase + addr_t'(idx * 4) + addr_t'($urandom_range(0, 3));
          if (is_write) begin
            run_write(addr, data, strb, RespSlvErr);
          end
          run_read(addr, rom_model[idx], RespOkay);
        end
        1: begin
          // Mostly a small window so reads hit written words
          idx  = ($urandom_range(0, 3) == 0) ? $urandom_range(0, SramWords - 1)
                                             : $urandom_range(0, 31);
          addr = SramBase + addr_t'(idx * 4) + addr_t'($urandom_range(0, 3));
          if (is_write) begin
            run_write(addr, data, strb, RespOkay);
            sram_model[idx] = merge_bytes(sram_model[idx], data, strb);
          end else begin
            run_read(addr, sram_model[idx], RespOkay);
          end
        end
        default: begin
          addr = pick_unmapped();
          if (is_write) begin
            run_write(addr, data, strb, RespDecErr);
          end else begin
            run_read(addr, '0, RespDecErr);
          end
        end
      endcase
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== hdl/boot_rom.hex ====
// Boot image words, index 0 first, one 32-bit hex word per line
00000297
01c28293
30529073
80001137
ffc10113
00000513
00000593
0100006f
00000013
00000013
10500073
ffdff06f
deadbeef
cafef00d
0badc0de
12345678

// ==== tb.f ====
hdl/soc_mem_pkg.sv
hdl/axil_front.sv
hdl/boot_rom.sv
hdl/sram_bank.sv
hdl/resp_merge.sv
hdl/soc_mem_top.sv
tests/tb_soc_mem.sv
